// File: design/piton_shell_macros.svh
// widths, pipe depths, register map and identification words for the piton shell glue
`ifndef PITON_SHELL_MACROS_SVH
`define PITON_SHELL_MACROS_SVH

////////////////////////////////////////////////////////////
// board side widths
`define SHELL_SW_W          16      // virtual dip switches
`define SHELL_LED_W         16      // virtual leds
`define SHELL_CORE_LED_W    8       // leds the core can drive, rest read zero
`define SHELL_DIMM_CNT      3       // per-dimm ready flags

////////////////////////////////////////////////////////////
// pipe depths
`define SHELL_RST_STAGES    4       // soft reset pipe ahead of the release flops
`define SHELL_SYNC_STAGES   2       // plain two-flop synchronizer
`define SHELL_SOFT_RST_BIT  15      // switch that acts as host soft reset

////////////////////////////////////////////////////////////
// register port
`define SHELL_CSR_ADDR_W    3
`define SHELL_CSR_DATA_W    32

// fixed identification words
`define SHELL_ID0           32'h5049_544e
`define SHELL_ID1           32'h0001_0f1a

// register addresses
`define SHELL_ADDR_ID0      3'd0
`define SHELL_ADDR_ID1      3'd1
`define SHELL_ADDR_SW       3'd2
`define SHELL_ADDR_LED      3'd3
`define SHELL_ADDR_DDR      3'd4

`endif

// File: design/shell_board_pkg.sv
// board-facing types: switch, led and dimm-ready words, board input and output bundles
`include "piton_shell_macros.svh"

package shell_board_pkg;

    ////////////////////////////////////////////////////////////
    // single words

    typedef logic [`SHELL_SW_W-1:0]     sw_word_t;      // virtual dip switches
    typedef logic [`SHELL_LED_W-1:0]    led_word_t;     // virtual leds
    typedef logic [`SHELL_DIMM_CNT-1:0] dimm_ready_t;   // one bit per dimm

    ////////////////////////////////////////////////////////////
    // board bundles

    // raw inputs from the shell, asynchronous to piton_clk
    typedef struct packed
    {
        sw_word_t    sw;                // switch word, bit 15 is soft reset
        dimm_ready_t dimm_ready;        // per-dimm calibration done
        logic        shell_ddr_ready;   // shell side memory ready
    } board_in_t;

    // outputs toward the shell
    typedef struct packed
    {
        led_word_t leds;                // staged led register
        logic      core_rst_n;          // core reset, active low
        logic      ddr_ready;           // all memory ready, synchronized
    } board_out_t;

endpackage

// File: design/shell_csr_pkg.sv
// register-port types: address map enum, request and response bundles
`include "piton_shell_macros.svh"

package shell_csr_pkg;

    ////////////////////////////////////////////////////////////
    // address map

    // 5..7 are unmapped and read zero
    typedef enum logic [`SHELL_CSR_ADDR_W-1:0]
    {
        CSR_ID0 = `SHELL_ADDR_ID0,  // fixed id word 0
        CSR_ID1 = `SHELL_ADDR_ID1,  // fixed id word 1
        CSR_SW  = `SHELL_ADDR_SW,   // synchronized switches
        CSR_LED = `SHELL_ADDR_LED,  // led register
        CSR_DDR = `SHELL_ADDR_DDR   // memory status
    } csr_addr_t;

    typedef logic [`SHELL_CSR_DATA_W-1:0] csr_data_t;

    ////////////////////////////////////////////////////////////
    // four-phase handshake bundles

    // host side, held stable from req rise until ack is seen
    typedef struct packed
    {
        logic      req;     // transfer request
        logic      write;   // 1 write, 0 read
        csr_addr_t addr;    // register address
        csr_data_t wdata;   // write data
    } csr_req_t;

    // slave side
    typedef struct packed
    {
        logic      ack;     // follows req one cycle late
        csr_data_t rdata;   // valid while ack is high
    } csr_rsp_t;

endpackage

// File: design/sync_pipe.sv
// resettable flop pipe, payload given as a type parameter
`timescale 1ns/1ps

module sync_pipe
#(
    parameter type payload_t = logic,   // word carried down the pipe
    parameter int  STAGES    = 2        // number of flops, at least 1
)
(
    input  logic     piton_clk,
    input  logic     piton_rst_n,
    input  payload_t din,
    output payload_t dout
);

    payload_t stage_q [STAGES];     // stage 0 samples din

    always_ff @(posedge piton_clk)
    begin
        if (!piton_rst_n)
        begin
            for (int i = 0; i < STAGES; i++)
            begin
                stage_q[i] <= '0;   // whole chain clears
            end
        end
        else
        begin
            stage_q[0] <= din;
            for (int i = 1; i < STAGES; i++)
            begin
                stage_q[i] <= stage_q[i-1];     // shift toward dout
            end
        end
    end

    // last stage is the synchronized copy
    assign dout = stage_q[STAGES-1];

endmodule

// File: design/reset_conditioner.sv
// soft reset conditioning: deep pipe plus two-flop release stage giving the core reset
`timescale 1ns/1ps
`include "piton_shell_macros.svh"

module reset_conditioner
(
    input  logic piton_clk,
    input  logic piton_rst_n,
    input  logic soft_rst_n,    // synchronized switch bit, low requests reset
    output logic core_rst_n     // active low reset to the core
);

    logic pipe_rst_n;       // soft reset after the deep pipe
    logic pre_rst_n_q;      // first release flop
    logic core_rst_n_q;     // second release flop, drives the core

    ////////////////////////////////////////////////////////////
    // deep pipe, gives placement room toward the core

    sync_pipe
    #(
        .payload_t  (logic),
        .STAGES     (`SHELL_RST_STAGES)
    )
    u_soft_rst_pipe
    (
        .piton_clk  (piton_clk),
        .piton_rst_n(piton_rst_n),
        .din        (soft_rst_n),
        .dout       (pipe_rst_n)
    );

    ////////////////////////////////////////////////////////////
    // release stage
    // assert on the first edge that sees the pipe low,
    // release only after a one has walked through both flops

    always_ff @(posedge piton_clk)
    begin
        if (!piton_rst_n || !pipe_rst_n)
        begin
            pre_rst_n_q  <= 1'b0;
            core_rst_n_q <= 1'b0;
        end
        else
        begin
            pre_rst_n_q  <= 1'b1;           // shift a one in
            core_rst_n_q <= pre_rst_n_q;
        end
    end

    assign core_rst_n = core_rst_n_q;

endmodule

// File: design/board_io_sync.sv
// board input synchronizers, combined memory-ready sync and led output staging
`timescale 1ns/1ps
`include "piton_shell_macros.svh"

module board_io_sync
(
    input  logic                        piton_clk,
    input  logic                        piton_rst_n,
    input  shell_board_pkg::sw_word_t   board_sw,           // raw switches
    input  shell_board_pkg::dimm_ready_t dimm_ready,        // raw per-dimm ready
    input  logic                        shell_ddr_ready,    // raw shell memory ready
    input  shell_board_pkg::led_word_t  led_reg,            // from the register port
    output shell_board_pkg::sw_word_t   sw_sync,
    output shell_board_pkg::dimm_ready_t dimm_sync,
    output logic                        ddr_ready,          // all memory ready
    output shell_board_pkg::led_word_t  leds                // toward the pins
);

    import shell_board_pkg::*;

    logic ddr_ready_raw;    // combine before sync so one bit crosses

    ////////////////////////////////////////////////////////////
    // switches

    sync_pipe #(.payload_t(sw_word_t), .STAGES(`SHELL_SYNC_STAGES)) u_sw_sync
    (
        .piton_clk  (piton_clk),
        .piton_rst_n(piton_rst_n),
        .din        (board_sw),
        .dout       (sw_sync)
    );

    ////////////////////////////////////////////////////////////
    // memory ready

    // every dimm and the shell flag have to agree
    assign ddr_ready_raw = (&dimm_ready) & shell_ddr_ready;

    sync_pipe #(.payload_t(dimm_ready_t), .STAGES(`SHELL_SYNC_STAGES)) u_dimm_sync
    (
        .piton_clk  (piton_clk),
        .piton_rst_n(piton_rst_n),
        .din        (dimm_ready),       // per-dimm copy for the status word
        .dout       (dimm_sync)
    );

    sync_pipe #(.payload_t(logic), .STAGES(`SHELL_SYNC_STAGES)) u_ready_sync
    (
        .piton_clk  (piton_clk),
        .piton_rst_n(piton_rst_n),
        .din        (ddr_ready_raw),
        .dout       (ddr_ready)
    );

    ////////////////////////////////////////////////////////////
    // leds

    // two flops toward the pins
    sync_pipe #(.payload_t(led_word_t), .STAGES(`SHELL_SYNC_STAGES)) u_led_stage
    (
        .piton_clk  (piton_clk),
        .piton_rst_n(piton_rst_n),
        .din        (led_reg),
        .dout       (leds)
    );

endmodule

// File: design/csr_port.sv
// four-phase register slave: led register, id words, switch and memory status read mux
`timescale 1ns/1ps
`include "piton_shell_macros.svh"

module csr_port
(
    input  logic                         piton_clk,
    input  logic                         piton_rst_n,
    input  shell_csr_pkg::csr_req_t      csr_req,
    output shell_csr_pkg::csr_rsp_t      csr_rsp,
    input  shell_board_pkg::sw_word_t    sw_sync,   // synchronized switches
    input  shell_board_pkg::dimm_ready_t dimm_sync, // synchronized dimm flags
    input  logic                         ddr_ready, // synchronized combined ready
    output shell_board_pkg::led_word_t   led_reg
);

    import shell_csr_pkg::*;

    logic                           ack_q;      // handshake ack
    logic                           xfer_start; // first cycle of a transfer
    csr_data_t                      rd_data;    // read mux output
    csr_data_t                      rdata_q;    // captured read data
    logic [`SHELL_CORE_LED_W-1:0]   led_core_q; // writable led bits

    ////////////////////////////////////////////////////////////
    // handshake

    // req seen high while ack still low
    assign xfer_start = csr_req.req && !ack_q;

    always_ff @(posedge piton_clk)
    begin
        if (!piton_rst_n)
        begin
            ack_q <= 1'b0;
        end
        else
        begin
            ack_q <= csr_req.req;   // rises after req, falls after req drops
        end
    end

    ////////////////////////////////////////////////////////////
    // led register

    always_ff @(posedge piton_clk)
    begin
        if (!piton_rst_n)
        begin
            led_core_q <= '0;
        end
        else if (xfer_start && csr_req.write && (csr_req.addr == CSR_LED))
        begin
            led_core_q <= csr_req.wdata[`SHELL_CORE_LED_W-1:0];  // same edge as ack
        end
    end

    // upper led bits are never driven by the core
    assign led_reg = {{(`SHELL_LED_W - `SHELL_CORE_LED_W){1'b0}}, led_core_q};

    ////////////////////////////////////////////////////////////
    // read mux

    always_comb
    begin
        rd_data = '0;   // unmapped addresses read zero
        case (csr_req.addr)
            CSR_ID0:
            begin
                rd_data = `SHELL_ID0;
            end
            CSR_ID1:
            begin
                rd_data = `SHELL_ID1;
            end
            CSR_SW:
            begin
                rd_data[`SHELL_SW_W-1:0] = sw_sync;         // zero extended
            end
            CSR_LED:
            begin
                rd_data[`SHELL_LED_W-1:0] = led_reg;
            end
            CSR_DDR:
            begin
                rd_data[`SHELL_DIMM_CNT-1:0] = dimm_sync;   // bits 2..0
                rd_data[`SHELL_DIMM_CNT]     = ddr_ready;   // bit 3
            end
            default:
            begin
                rd_data = '0;
            end
        endcase
    end

    // capture once per transfer, held while ack is up
    always_ff @(posedge piton_clk)
    begin
        if (xfer_start)
        begin
            rdata_q <= rd_data;
        end
    end

    assign csr_rsp = '{ack: ack_q, rdata: rdata_q};

endmodule

// File: design/piton_shell_top.sv
// top level of the shell glue: board sync, reset conditioning and host register port
`timescale 1ns/1ps
`include "piton_shell_macros.svh"

module piton_shell_top
(
    input  logic                        piton_clk,
    input  logic                        piton_rst_n,
    input  shell_board_pkg::board_in_t  board_in,   // raw board inputs
    output shell_board_pkg::board_out_t board_out,  // leds, core reset, ready
    input  shell_csr_pkg::csr_req_t     csr_req,    // host request
    output shell_csr_pkg::csr_rsp_t     csr_rsp     // host response
);

    import shell_board_pkg::*;

    sw_word_t    sw_sync;       // switches in the core domain
    dimm_ready_t dimm_sync;     // dimm flags in the core domain
    logic        ddr_ready;     // combined memory ready
    led_word_t   led_reg;       // led register from the host
    led_word_t   leds;          // staged leds
    logic        core_rst_n;    // conditioned core reset

    ////////////////////////////////////////////////////////////
    // board inputs and led staging

    board_io_sync u_board_io_sync
    (
        .piton_clk      (piton_clk),
        .piton_rst_n    (piton_rst_n),
        .board_sw       (board_in.sw),
        .dimm_ready     (board_in.dimm_ready),
        .shell_ddr_ready(board_in.shell_ddr_ready),
        .led_reg        (led_reg),
        .sw_sync        (sw_sync),
        .dimm_sync      (dimm_sync),
        .ddr_ready      (ddr_ready),
        .leds           (leds)
    );

    ////////////////////////////////////////////////////////////
    // core reset from the soft reset switch

    reset_conditioner u_reset_conditioner
    (
        .piton_clk  (piton_clk),
        .piton_rst_n(piton_rst_n),
        .soft_rst_n (sw_sync[`SHELL_SOFT_RST_BIT]),
        .core_rst_n (core_rst_n)
    );

    ////////////////////////////////////////////////////////////
    // host register port

    csr_port u_csr_port
    (
        .piton_clk  (piton_clk),
        .piton_rst_n(piton_rst_n),
        .csr_req    (csr_req),
        .csr_rsp    (csr_rsp),
        .sw_sync    (sw_sync),
        .dimm_sync  (dimm_sync),
        .ddr_ready  (ddr_ready),
        .led_reg    (led_reg)
    );

    // outputs toward the shell
    assign board_out = '{leds: leds, core_rst_n: core_rst_n, ddr_ready: ddr_ready};

endmodule

// File: tests/tb_piton_shell.sv
// testbench for the shell glue: clock, reset, lcg stimulus, reference model, checks, timeout
`timescale 1ns/1ps
`include "piton_shell_macros.svh"

module tb_piton_shell;

    import shell_board_pkg::*;
    import shell_csr_pkg::*;

    localparam int ACK_WAIT = 8;                // cycles allowed per handshake phase
    localparam int XFER_CYC = 2 * ACK_WAIT;     // worst case for one transfer
    localparam int SETTLE   = 4;                // board inputs held before reading
    localparam int N_RAND   = 24;               // iterations per random test

    ////////////////////////////////////////////////////////////
    // worst case cycles per test, the limit is twice the sum
    localparam int T_RESET  = 16 + 1 + SETTLE + 2 * XFER_CYC;
    localparam int T_LED    = N_RAND * (2 * XFER_CYC + 3);
    localparam int T_SW     = N_RAND * (SETTLE + XFER_CYC) + 8;
    localparam int T_DDR    = N_RAND * (SETTLE + XFER_CYC);
    localparam int T_SOFT   = 7 + 2 + XFER_CYC + 8;
    localparam int T_UNMAP  = 3 * 3 * XFER_CYC;
    localparam int CYCLE_LIMIT = 2 * (T_RESET + T_LED + T_SW + T_DDR + T_SOFT + T_UNMAP);

    logic        piton_clk;
    logic        piton_rst_n;
    board_in_t   board_in;
    board_out_t  board_out;
    csr_req_t    csr_req;
    csr_rsp_t    csr_rsp;

    logic [31:0] lcg_state;         // random generator state
    led_word_t   led_model;         // last value written to the led register
    sw_word_t    sw_model;          // switch word on the board
    int          cycle_cnt = 0;

    piton_shell_top u_dut
    (
        .piton_clk  (piton_clk),
        .piton_rst_n(piton_rst_n),
        .board_in   (board_in),
        .board_out  (board_out),
        .csr_req    (csr_req),
        .csr_rsp    (csr_rsp)
    );

    initial
    begin
        piton_clk = 1'b0;
        forever #5 piton_clk = ~piton_clk;
    end

    // run limit
    always @(posedge piton_clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT)
        begin
            fail_run("timeout, the run went past its cycle limit");
        end
    end

    ////////////////////////////////////////////////////////////
    // helpers

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
            fail_run("value check failed");
        end
    endtask

    // n rising edges, then the drive delay
    task automatic step(input int n);
        repeat (n)
        begin
            @(posedge piton_clk);
            #1;
        end
    endtask

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // one four-phase transfer, returns after ack has dropped
    task automatic csr_xfer(input logic wr, input logic [2:0] addr, input csr_data_t wdata,
                            output csr_data_t rdata);
        int waited;
        csr_req.write = wr;
        csr_req.addr  = csr_addr_t'(addr);
        csr_req.wdata = wdata;
        csr_req.req   = 1'b1;
        waited = 0;
        step(1);
        while (!csr_rsp.ack)
        begin
            waited++;
            if (waited > ACK_WAIT)
            begin
                fail_run("the register port never raised ack for a request");
            end
            step(1);
        end
        rdata = csr_rsp.rdata;      // valid while ack is high
        csr_req.req = 1'b0;
        waited = 0;
        step(1);
        while (csr_rsp.ack)
        begin
            waited++;
            if (waited > ACK_WAIT)
            begin
                fail_run("the register port kept ack high after req dropped");
            end
            step(1);
        end
    endtask

    task automatic csr_write(input logic [2:0] addr, input csr_data_t wdata);
        csr_data_t unused_rd;
        csr_xfer(1'b1, addr, wdata, unused_rd);
    endtask

    task automatic csr_read(input logic [2:0] addr, output csr_data_t rdata);
        csr_xfer(1'b0, addr, '0, rdata);
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus and checks

    initial
    begin
        csr_data_t   r;
        csr_data_t   rd;
        dimm_ready_t dimm;
        logic        shell_rdy;
        logic        all_rdy;
        lcg_state   = 32'hbd311366;
        led_model   = '0;
        sw_model    = '0;
        piton_rst_n = 1'b0;
        board_in    = '0;
        csr_req     = '0;
        repeat (16) @(posedge piton_clk);
        #1;
        piton_rst_n = 1'b1;

        // reset values and id words
        step(1);
        check("reset_ack", 32'd0, {31'd0, csr_rsp.ack});
        check("reset_leds", 32'd0, {16'd0, board_out.leds});
        check("reset_core_rst", 32'd0, {31'd0, board_out.core_rst_n});
        step(SETTLE);
        check("reset_ready", 32'd0, {31'd0, board_out.ddr_ready});
        csr_read(`SHELL_ADDR_ID0, rd);
        check("id0", `SHELL_ID0, rd);
        csr_read(`SHELL_ADDR_ID1, rd);
        check("id1", `SHELL_ID1, rd);

        // led writes, only the low core bits stick
        for (int i = 0; i < N_RAND; i++)
        begin
            r = next_rand();
            csr_write(`SHELL_ADDR_LED, r);
            led_model = '0;
            led_model[`SHELL_CORE_LED_W-1:0] = r[`SHELL_CORE_LED_W-1:0];
            csr_read(`SHELL_ADDR_LED, rd);
            check("led_readback", {16'd0, led_model}, rd);
            step(3);    // two staging flops toward the pins
            check("led_pins", {16'd0, led_model}, {16'd0, board_out.leds});
        end

        // switches with soft reset held off
        for (int i = 0; i < N_RAND; i++)
        begin
            r = next_rand();
            sw_model = r[15:0];
            sw_model[`SHELL_SOFT_RST_BIT] = 1'b1;
            board_in.sw = sw_model;
            step(SETTLE);
            csr_read(`SHELL_ADDR_SW, rd);
            check("sw_readback", {16'd0, sw_model}, rd);
        end
        step(8);
        check("core_rst_released", 32'd1, {31'd0, board_out.core_rst_n});

        // memory status word and combined ready pin
        for (int i = 0; i < N_RAND; i++)
        begin
            r = next_rand();
            dimm = r[2:0];
            shell_rdy = r[3];
            if (r[5:4] == 2'b00)
            begin
                dimm = '1;      // steer toward the all-ready case
                shell_rdy = 1'b1;
            end
            all_rdy = (&dimm) & shell_rdy;
            board_in.dimm_ready = dimm;
            board_in.shell_ddr_ready = shell_rdy;
            step(SETTLE);
            check("ddr_ready_pin", {31'd0, all_rdy}, {31'd0, board_out.ddr_ready});
            csr_read(`SHELL_ADDR_DDR, rd);
            check("ddr_status", {28'd0, all_rdy, dimm}, rd);
        end

        // soft reset, 2 sync + 4 pipe + 1 release flop to assert
        board_in.sw[`SHELL_SOFT_RST_BIT] = 1'b0;
        for (int i = 1; i <= 7; i++)
        begin
            step(1);
            check("soft_rst_assert", (i < 7) ? 32'd1 : 32'd0, {31'd0, board_out.core_rst_n});
        end
        step(2);
        csr_read(`SHELL_ADDR_LED, rd);
        check("soft_rst_led_kept", {16'd0, led_model}, rd);
        board_in.sw[`SHELL_SOFT_RST_BIT] = 1'b1;
        for (int i = 1; i <= 8; i++)       // release takes one more flop
        begin
            step(1);
            check("soft_rst_release", (i < 8) ? 32'd0 : 32'd1, {31'd0, board_out.core_rst_n});
        end

        // unmapped addresses
        for (int a = 5; a < 8; a++)
        begin
            r = next_rand();
            csr_write(3'(a), r);
            csr_read(3'(a), rd);
            check("unmapped_read", 32'd0, rd);
            csr_read(`SHELL_ADDR_LED, rd);
            check("unmapped_write", {16'd0, led_model}, rd);
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: build.f
+incdir+design
design/shell_board_pkg.sv
design/shell_csr_pkg.sv
design/sync_pipe.sv
design/reset_conditioner.sv
design/board_io_sync.sv
design/csr_port.sv
design/piton_shell_top.sv
tests/tb_piton_shell.sv

// File: Makefile
# verilator build and run for the piton shell glue

VERILATOR ?= verilator
TOP       ?= tb_piton_shell
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
PASS_TEXT ?= *** PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run, then search the log for the pass line"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qF "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
